// ==== biquad_config.svh ====
//**********************************************************
// Biquad filter configuration
//**********************************************************
`ifndef BIQUAD_CONFIG_SVH
`define BIQUAD_CONFIG_SVH

// Width of the ADC samples on x_adc_i and y_o
`define BQ_ADC_BITS 10

// Fixed-point split of a coefficient word
`define BQ_WHOLE_BITS 10
`define BQ_FRAC_BITS 54

// Headroom for the five summed feed-forward terms
`define BQ_GUARD_BITS 3

// Registered stages between plain coefficients and look-ahead taps
`define BQ_LAT_DEPTH 4

`endif

// ==== biquad_pkg.sv ====
//**********************************************************
// Biquad fixed-point types
//**********************************************************
`include "biquad_config.svh"

package biquad_pkg;

    localparam int COEF_BITS = `BQ_WHOLE_BITS + `BQ_FRAC_BITS;
    localparam int ACC_BITS = COEF_BITS + `BQ_GUARD_BITS;

    typedef logic signed [COEF_BITS-1:0] coef_t;
    typedef logic signed [ACC_BITS-1:0] acc_t;
    typedef logic signed [`BQ_ADC_BITS-1:0] sample_t;

    // Full product with the extra fraction bits dropped
    function automatic coef_t coef_mul(coef_t a, coef_t b);
        logic signed [2*COEF_BITS-1:0] prod;
        prod = a * b;
        return prod[`BQ_FRAC_BITS +: COEF_BITS];
    endfunction

    // Accumulator times coefficient kept at accumulator width
    function automatic acc_t acc_mul(acc_t a, coef_t b);
        logic signed [ACC_BITS+COEF_BITS-1:0] prod;
        prod = a * b;
        return prod[`BQ_FRAC_BITS +: ACC_BITS];
    endfunction

endpackage

// ==== delay_pipe.sv ====
//**********************************************************
// Enabled delay line
//**********************************************************
`timescale 1ns/100ps

module delay_pipe #(
    parameter type T = logic,
    parameter int DEPTH = 1
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic en_i,
    input  T     d_i,
    output T     q_o
);

    T stage [DEPTH];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (en_i) begin
            stage[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q_o = stage[DEPTH-1];

endmodule

// ==== filter_control.sv ====
//**********************************************************
// Biquad control and sample enable
//**********************************************************
`timescale 1ns/100ps
`include "biquad_config.svh"

module filter_control (
    input  logic clk_i,
    input  logic rst_i,
    input  logic coefficients_ready_i,
    input  logic sample_ready_i,
    output logic blk_rst_o,
    output logic sample_en_o,
    output logic valid_o
);

    // Input, product, sum_ab and output registers between x and y_o
    localparam int OUT_DEPTH = 4;

    logic taps_ready;

    // Datapath held in reset until coefficients are declared ready
    assign blk_rst_o = rst_i | ~coefficients_ready_i;

    // Follows the look-ahead tap pipeline clock for clock
    delay_pipe #(
        .T     (logic),
        .DEPTH (`BQ_LAT_DEPTH)
    ) u_settle (
        .clk_i (clk_i),
        .rst_i (blk_rst_o),
        .en_i  (1'b1),
        .d_i   (1'b1),
        .q_o   (taps_ready)
    );

    // Strobes before the taps settle are dropped
    assign sample_en_o = sample_ready_i & taps_ready;

    // Valid once the first sample reaches y_o
    delay_pipe #(
        .T     (logic),
        .DEPTH (OUT_DEPTH)
    ) u_valid (
        .clk_i (clk_i),
        .rst_i (blk_rst_o),
        .en_i  (sample_en_o),
        .d_i   (1'b1),
        .q_o   (valid_o)
    );

endmodule

// ==== lat_coef_engine.sv ====
//**********************************************************
// Look-ahead coefficient engine
//**********************************************************
`timescale 1ns/100ps
`include "biquad_config.svh"

module lat_coef_engine (
    input  logic              clk_i,
    input  logic              rst_i,
    input  biquad_pkg::coef_t b0_i,
    input  biquad_pkg::coef_t b1_i,
    input  biquad_pkg::coef_t b2_i,
    input  biquad_pkg::coef_t a1_i,
    input  biquad_pkg::coef_t a2_i,
    output biquad_pkg::coef_t b0_lat_o,
    output biquad_pkg::coef_t b1_lat_o,
    output biquad_pkg::coef_t b2_lat_o,
    output biquad_pkg::coef_t b3_lat_o,
    output biquad_pkg::coef_t b4_lat_o,
    output biquad_pkg::coef_t a1_lat_o,
    output biquad_pkg::coef_t a2_lat_o
);

    import biquad_pkg::*;

    // Feedback gains with c = -a, so y[n] = c1 y[n-1] + c2 y[n-2] + ...
    coef_t c1, c2, c1_1;
    coef_t c1b0, c1b1, c1b2, c2b0, c2b1, c2b2, c1c2, c1sq, c2sq;
    coef_t b1_s2, b2_s2, c1c1b0, c2b0_s2, c1c1b1, c2b1_s2, c1b2_s2;
    coef_t c1c1b2, c2b2_s2, c1cube, c1c2x2, c1c1c2, c2sq_s2;
    coef_t b2a_s3, b2b_s3, b3_s3, b4_s3, a1_s3, a2_s3;

    assign c1 = -a1_i;
    assign c2 = -a2_i;

    // b0 passes untouched
    delay_pipe #(
        .T     (coef_t),
        .DEPTH (`BQ_LAT_DEPTH)
    ) u_b0_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .en_i  (1'b1),
        .d_i   (b0_i),
        .q_o   (b0_lat_o)
    );

    // c1 aligned with the stage 1 products
    delay_pipe #(
        .T     (coef_t),
        .DEPTH (1)
    ) u_c1_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .en_i  (1'b1),
        .d_i   (c1),
        .q_o   (c1_1)
    );

    // b1 + c1 b0 is ready after stage 2
    delay_pipe #(
        .T     (coef_t),
        .DEPTH (2)
    ) u_b1_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .en_i  (1'b1),
        .d_i   (b1_s2),
        .q_o   (b1_lat_o)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            c1b0 <= '0;
            c1b1 <= '0;
            c1b2 <= '0;
            c2b0 <= '0;
            c2b1 <= '0;
            c2b2 <= '0;
            c1c2 <= '0;
            c1sq <= '0;
            c2sq <= '0;
            b1_s2 <= '0;
            b2_s2 <= '0;
            c1c1b0 <= '0;
            c2b0_s2 <= '0;
            c1c1b1 <= '0;
            c2b1_s2 <= '0;
            c1b2_s2 <= '0;
            c1c1b2 <= '0;
            c2b2_s2 <= '0;
            c1cube <= '0;
            c1c2x2 <= '0;
            c1c1c2 <= '0;
            c2sq_s2 <= '0;
            b2a_s3 <= '0;
            b2b_s3 <= '0;
            b3_s3 <= '0;
            b4_s3 <= '0;
            a1_s3 <= '0;
            a2_s3 <= '0;
            b2_lat_o <= '0;
            b3_lat_o <= '0;
            b4_lat_o <= '0;
            a1_lat_o <= '0;
            a2_lat_o <= '0;
        end else begin
            // Stage 1 first-order products
            c1b0 <= coef_mul(c1, b0_i);
            c1b1 <= coef_mul(c1, b1_i);
            c1b2 <= coef_mul(c1, b2_i);
            c2b0 <= coef_mul(c2, b0_i);
            c2b1 <= coef_mul(c2, b1_i);
            c2b2 <= coef_mul(c2, b2_i);
            c1c2 <= coef_mul(c1, c2);
            c1sq <= coef_mul(c1, c1);
            c2sq <= coef_mul(c2, c2);
            // Stage 2 second-order products reuse the c1 terms
            b1_s2 <= b1_i + c1b0;
            b2_s2 <= b2_i + c1b1;
            c1c1b0 <= coef_mul(c1_1, c1b0);
            c2b0_s2 <= c2b0;
            c1c1b1 <= coef_mul(c1_1, c1b1);
            c2b1_s2 <= c2b1;
            c1b2_s2 <= c1b2;
            c1c1b2 <= coef_mul(c1_1, c1b2);
            c2b2_s2 <= c2b2;
            c1cube <= coef_mul(c1_1, c1sq);
            c1c2x2 <= c1c2 <<< 1;
            c1c1c2 <= coef_mul(c1_1, c1c2);
            c2sq_s2 <= c2sq;
            // Stage 3 partial sums
            b2a_s3 <= b2_s2;
            b2b_s3 <= c1c1b0 + c2b0_s2;
            b3_s3 <= c1b2_s2 + c1c1b1 + c2b1_s2;
            b4_s3 <= c1c1b2 + c2b2_s2;
            a1_s3 <= c1cube + c1c2x2;
            a2_s3 <= c1c1c2 + c2sq_s2;
            // Stage 4
            b2_lat_o <= b2a_s3 + b2b_s3;
            b3_lat_o <= b3_s3;
            b4_lat_o <= b4_s3;
            a1_lat_o <= a1_s3;
            a2_lat_o <= a2_s3;
        end
    end

endmodule

// ==== fir_section.sv ====
//**********************************************************
// Transposed feed-forward section
//**********************************************************
`timescale 1ns/100ps
`include "biquad_config.svh"

module fir_section (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                en_i,
    input  biquad_pkg::sample_t x_i,
    input  biquad_pkg::coef_t   b0_lat_i,
    input  biquad_pkg::coef_t   b1_lat_i,
    input  biquad_pkg::coef_t   b2_lat_i,
    input  biquad_pkg::coef_t   b3_lat_i,
    input  biquad_pkg::coef_t   b4_lat_i,
    output biquad_pkg::acc_t    sum_b_o
);

    import biquad_pkg::*;

    localparam int EXT_BITS = ACC_BITS - `BQ_FRAC_BITS - `BQ_ADC_BITS;

    sample_t x_r;
    acc_t    x_ext;
    acc_t    xb0, xb1, xb2, xb3, xb4, xb4_p;
    acc_t    s34, s234, s1234;

    // Sample as an integer in fixed point
    assign x_ext = {{EXT_BITS{x_r[`BQ_ADC_BITS-1]}}, x_r, {`BQ_FRAC_BITS{1'b0}}};

    assign xb4_p = acc_mul(x_ext, b4_lat_i);

    // b4 term sits one strobe deeper than the other taps
    delay_pipe #(
        .T     (acc_t),
        .DEPTH (2)
    ) u_xb4_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .en_i  (en_i),
        .d_i   (xb4_p),
        .q_o   (xb4)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            x_r <= '0;
            xb0 <= '0;
            xb1 <= '0;
            xb2 <= '0;
            xb3 <= '0;
            s34 <= '0;
            s234 <= '0;
            s1234 <= '0;
        end else if (en_i) begin
            x_r <= x_i;
            xb0 <= acc_mul(x_ext, b0_lat_i);
            xb1 <= acc_mul(x_ext, b1_lat_i);
            xb2 <= acc_mul(x_ext, b2_lat_i);
            xb3 <= acc_mul(x_ext, b3_lat_i);
            s34 <= xb3 + xb4;
            s234 <= xb2 + s34;
            s1234 <= xb1 + s234;
        end
    end

    assign sum_b_o = xb0 + s1234;

endmodule

// ==== feedback_section.sv ====
//**********************************************************
// Look-ahead recursive section
//**********************************************************
`timescale 1ns/100ps
`include "biquad_config.svh"

module feedback_section (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                en_i,
    input  biquad_pkg::acc_t    sum_b_i,
    input  biquad_pkg::coef_t   a1_lat_i,
    input  biquad_pkg::coef_t   a2_lat_i,
    output biquad_pkg::sample_t y_o
);

    import biquad_pkg::*;

    localparam int INT_BITS = ACC_BITS - `BQ_FRAC_BITS;
    localparam logic signed [INT_BITS-1:0] Y_MAX = (2 ** (`BQ_ADC_BITS - 1)) - 1;
    localparam logic signed [INT_BITS-1:0] Y_MIN = -(2 ** (`BQ_ADC_BITS - 1));

    acc_t    sum_ab, sum_a;
    acc_t    y3, y4;
    acc_t    y3a1, y4a2;
    logic signed [INT_BITS-1:0] y_int;
    sample_t y_sat;

    assign sum_ab = sum_b_i + sum_a;

    // Integer part of the newest output with the fraction dropped
    assign y_int = y3[`BQ_FRAC_BITS +: INT_BITS];

    always_comb begin
        if (y_int > Y_MAX) begin
            y_sat = Y_MAX[`BQ_ADC_BITS-1:0];
        end else if (y_int < Y_MIN) begin
            y_sat = Y_MIN[`BQ_ADC_BITS-1:0];
        end else begin
            y_sat = y_int[`BQ_ADC_BITS-1:0];
        end
    end

    // y3 holds sum_ab as the newest full-precision output.
    // The loop sees it three samples late through y3a1 and sum_a
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            y3 <= '0;
            y4 <= '0;
            y3a1 <= '0;
            y4a2 <= '0;
            sum_a <= '0;
            y_o <= '0;
        end else if (en_i) begin
            y3 <= sum_ab;
            y4 <= y3;
            y3a1 <= acc_mul(y3, a1_lat_i);
            y4a2 <= acc_mul(y4, a2_lat_i);
            sum_a <= y3a1 + y4a2;
            y_o <= y_sat;
        end
    end

endmodule

// ==== biquad_lat_top.sv ====
//**********************************************************
// Look-ahead biquad top level
//**********************************************************
`timescale 1ns/100ps

module biquad_lat_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                coefficients_ready_i,
    input  logic                sample_ready_i,
    input  biquad_pkg::sample_t x_adc_i,
    input  biquad_pkg::coef_t   b0_i,
    input  biquad_pkg::coef_t   b1_i,
    input  biquad_pkg::coef_t   b2_i,
    input  biquad_pkg::coef_t   a1_i,
    input  biquad_pkg::coef_t   a2_i,
    output biquad_pkg::sample_t y_o,
    output logic                valid_o
);

    logic              blk_rst;
    logic              sample_en;
    biquad_pkg::coef_t b0_lat, b1_lat, b2_lat, b3_lat, b4_lat;
    biquad_pkg::coef_t a1_lat, a2_lat;
    biquad_pkg::acc_t  sum_b;

    filter_control u_ctrl (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .coefficients_ready_i (coefficients_ready_i),
        .sample_ready_i       (sample_ready_i),
        .blk_rst_o            (blk_rst),
        .sample_en_o          (sample_en),
        .valid_o              (valid_o)
    );

    lat_coef_engine u_coef (
        .clk_i    (clk_i),
        .rst_i    (blk_rst),
        .b0_i     (b0_i),
        .b1_i     (b1_i),
        .b2_i     (b2_i),
        .a1_i     (a1_i),
        .a2_i     (a2_i),
        .b0_lat_o (b0_lat),
        .b1_lat_o (b1_lat),
        .b2_lat_o (b2_lat),
        .b3_lat_o (b3_lat),
        .b4_lat_o (b4_lat),
        .a1_lat_o (a1_lat),
        .a2_lat_o (a2_lat)
    );

    fir_section u_fir (
        .clk_i    (clk_i),
        .rst_i    (blk_rst),
        .en_i     (sample_en),
        .x_i      (x_adc_i),
        .b0_lat_i (b0_lat),
        .b1_lat_i (b1_lat),
        .b2_lat_i (b2_lat),
        .b3_lat_i (b3_lat),
        .b4_lat_i (b4_lat),
        .sum_b_o  (sum_b)
    );

    feedback_section u_fb (
        .clk_i    (clk_i),
        .rst_i    (blk_rst),
        .en_i     (sample_en),
        .sum_b_i  (sum_b),
        .a1_lat_i (a1_lat),
        .a2_lat_i (a2_lat),
        .y_o      (y_o)
    );

endmodule

// ==== tb_clock_gen.sv ====
//**********************************************************
// Testbench clock source
//**********************************************************
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== tb_biquad_lat.sv ====
//**********************************************************
// Look-ahead biquad testbench
//**********************************************************
`timescale 1ns/100ps
`include "biquad_config.svh"

module tb_biquad_lat;

    import biquad_pkg::*;

    localparam int MAX_SAMPLES = 32;
    localparam int Y_FRAC = 24;
    localparam int Y_MAX = (2 ** (`BQ_ADC_BITS - 1)) - 1;
    localparam int Y_MIN = -(2 ** (`BQ_ADC_BITS - 1));

    logic    clk, rst, coef_ready, sample_ready, valid;
    sample_t x_adc, y;
    coef_t   b0, b1, b2, a1, a2;

    // b0 b1 b2 a1 a2 in units of 1/256
    int coef_q8 [5];
    int x_seq [MAX_SAMPLES];
    int y_exp [MAX_SAMPLES];
    int y_got [MAX_SAMPLES];
    int errors, test_errors, tests_run, tests_failed;

    tb_clock_gen #(.PERIOD_NS(20)) u_clk (.clk_o(clk));

    biquad_lat_top DUT (
        .clk_i                (clk),
        .rst_i                (rst),
        .coefficients_ready_i (coef_ready),
        .sample_ready_i       (sample_ready),
        .x_adc_i              (x_adc),
        .b0_i                 (b0),
        .b1_i                 (b1),
        .b2_i                 (b2),
        .a1_i                 (a1),
        .a2_i                 (a2),
        .y_o                  (y),
        .valid_o              (valid)
    );

    function automatic coef_t to_coef(input int q8);
        coef_t c;
        c = q8;
        return c <<< (`BQ_FRAC_BITS - 8);
    endfunction

    // Ends 2 ns past the n-th rising edge
    task automatic tick(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic check_value(input int got, input int exp, input string what);
        assert (got == exp) else begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic set_coefs(input int b0_q8, input int b1_q8, input int b2_q8,
                             input int a1_q8, input int a2_q8);
        coef_q8[0] = b0_q8;
        coef_q8[1] = b1_q8;
        coef_q8[2] = b2_q8;
        coef_q8[3] = a1_q8;
        coef_q8[4] = a2_q8;
        b0 = to_coef(b0_q8);
        b1 = to_coef(b1_q8);
        b2 = to_coef(b2_q8);
        a1 = to_coef(a1_q8);
        a2 = to_coef(a2_q8);
    endtask

    task automatic load_coefs(input int b0_q8, input int b1_q8, input int b2_q8,
                              input int a1_q8, input int a2_q8);
        coef_ready = 1'b0;
        set_coefs(b0_q8, b1_q8, b2_q8, a1_q8, a2_q8);
        tick(1);
        coef_ready = 1'b1;
        tick(6);
    endtask

    // Returns 2 ns after the clock that takes the strobe
    task automatic strobe(input int x);
        tick(3);
        x_adc = x;
        sample_ready = 1'b1;
        tick(1);
        sample_ready = 1'b0;
    endtask

    // Plain biquad in fixed point with outputs scaled by 2^Y_FRAC
    task automatic compute_model(input int n);
        longint w [MAX_SAMPLES];
        longint acc;
        longint q;
        for (int k = 0; k < n; k++) begin
            acc = 0;
            for (int i = 0; i < 3; i++) begin
                if (k >= i) acc += (longint'(coef_q8[i]) * x_seq[k-i]) <<< (Y_FRAC - 8);
            end
            if (k >= 1) acc -= (coef_q8[3] * w[k-1]) >>> 8;
            if (k >= 2) acc -= (coef_q8[4] * w[k-2]) >>> 8;
            w[k] = acc;
            q = acc >>> Y_FRAC;
            y_exp[k] = (q > Y_MAX) ? Y_MAX : (q < Y_MIN) ? Y_MIN : int'(q);
        end
    endtask

    // Three zero strobes flush the last samples out to y_o
    task automatic run_stream(input int n);
        int x;
        compute_model(n);
        for (int k = 0; k < n + 3; k++) begin
            x = (k < n) ? x_seq[k] : 0;
            strobe(x);
            check_value(valid, k >= 3, "valid_o");
            if (k >= 3) begin
                y_got[k-3] = y;
                check_value(y, y_exp[k-3], "y_o");
            end
        end
    endtask

    task automatic wait_valid_clear(input int max_clocks);
        int n;
        n = 0;
        while (valid !== 1'b0 && n < max_clocks) begin
            tick(1);
            n++;
        end
        if (valid !== 1'b0) begin
            $display("Timeout: valid_o did not clear within %0d clocks", max_clocks);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_reset_ignored();
        check_value(valid, 0, "valid_o after reset");
        check_value(y, 0, "y_o after reset");
        strobe(50);
        strobe(-50);
        set_coefs(256, 128, 64, 0, 0);
        tick(1);
        // Strobe held through the three clocks after ready rises
        coef_ready = 1'b1;
        x_adc = 77;
        sample_ready = 1'b1;
        tick(3);
        sample_ready = 1'b0;
        tick(3);
        for (int k = 0; k < 3; k++) begin
            strobe(0);
            check_value(valid, 0, "valid_o after early strobes");
        end
        finish_test("reset_and_ignored_strobes");
    endtask

    task automatic test_valid_timing();
        load_coefs(256, 0, 0, 0, 0);
        for (int k = 0; k < 6; k++) begin
            strobe(k);
            check_value(valid, k >= 3, "valid_o");
        end
        tick(3);
        check_value(valid, 1, "valid_o between strobes");
        finish_test("valid_timing");
    endtask

    task automatic test_fir(input string name, input int c0, input int c1, input int c2);
        load_coefs(c0, c1, c2, 0, 0);
        for (int k = 0; k < 24; k++) begin
            x_seq[k] = int'($urandom % 201) - 100;
        end
        run_stream(24);
        finish_test(name);
    endtask

    task automatic test_impulse(input string name, input int b0_q8, input int b1_q8,
                                input int b2_q8, input int a1_q8, input int a2_q8);
        load_coefs(b0_q8, b1_q8, b2_q8, a1_q8, a2_q8);
        for (int k = 0; k < 20; k++) begin
            x_seq[k] = (k == 0) ? 256 : 0;
        end
        run_stream(20);
        finish_test(name);
    endtask

    task automatic test_saturation();
        load_coefs(1024, 0, 0, 0, 0);
        for (int k = 0; k < 8; k++) begin
            x_seq[k] = (k % 2 == 0) ? 200 : -200;
        end
        run_stream(8);
        check_value(y_got[0], Y_MAX, "y_o positive clamp");
        check_value(y_got[1], Y_MIN, "y_o negative clamp");
        finish_test("saturation");
    endtask

    task automatic test_reload();
        load_coefs(256, 128, 64, 0, 0);
        for (int k = 0; k < 8; k++) begin
            x_seq[k] = 90 - 20 * k;
        end
        run_stream(8);
        coef_ready = 1'b0;
        wait_valid_clear(4);
        check_value(y, 0, "y_o after coefficient drop");
        test_fir("coefficient_reload", 128, -64, 192);
    endtask

    initial begin
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'he37));
        rst = 1'b1;
        coef_ready = 1'b0;
        sample_ready = 1'b0;
        x_adc = '0;
        set_coefs(0, 0, 0, 0, 0);
        tick(4);
        rst = 1'b0;
        test_reset_ignored();
        test_valid_timing();
        test_fir("pure_fir", 256, 128, 64);
        test_impulse("recursive_impulse", 256, 0, 0, -128, 64);
        // Every look-ahead tap and both loop gains nonzero
        test_impulse("lookahead_taps", 256, 64, 128, -128, 128);
        test_saturation();
        test_reload();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
biquad_pkg.sv
delay_pipe.sv
filter_control.sv
lat_coef_engine.sv
fir_section.sv
feedback_section.sv
biquad_lat_top.sv
tb_clock_gen.sv
tb_biquad_lat.sv

// ==== Bender.yml ====
package:
  name: biquad_lat

sources:
  - include_dirs:
      - .
    files:
      - biquad_pkg.sv
      - delay_pipe.sv
      - filter_control.sv
      - lat_coef_engine.sv
      - fir_section.sv
      - feedback_section.sv
      - biquad_lat_top.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - tb_biquad_lat.sv
